// File: include/xtea_config.svh
`ifndef XTEA_CONFIG_SVH
`define XTEA_CONFIG_SVH

`define XTEA_ROUNDS     32
`define XTEA_DELTA      32'h9E3779B9

`define XTEA_ADDR_KEY0  3'd0
`define XTEA_ADDR_KEY1  3'd1
`define XTEA_ADDR_KEY2  3'd2
`define XTEA_ADDR_KEY3  3'd3
`define XTEA_ADDR_MODE  3'd4

`endif

// File: src/xtea_pkg.sv
package xtea_pkg;

    // one 64-bit xtea block.
    typedef struct packed {
        logic [31:0] v0;
        logic [31:0] v1;
    } half_block_t;

    // two independent lanes in y0,z0,y1,z1 order.
    typedef struct packed {
        half_block_t lane_hi;
        half_block_t lane_lo;
    } data_block_t;

    typedef struct packed {
        logic [31:0] k0;
        logic [31:0] k1;
        logic [31:0] k2;
        logic [31:0] k3;
    } cipher_key_t;

    typedef enum logic {
        MODE_ENCRYPT = 1'b0,
        MODE_DECRYPT = 1'b1
    } cipher_mode_t;

    // single register write, applied when strobe is high.
    typedef struct packed {
        logic [2:0]  addr;
        logic [31:0] data;
        logic        strobe;
    } cfg_write_t;

    // half being updated this cycle.
    typedef enum logic {
        PHASE_V0 = 1'b0,
        PHASE_V1 = 1'b1
    } half_phase_t;

endpackage

// File: src/xtea_key_regs.sv
`include "xtea_config.svh"

module xtea_key_regs (
    input  logic                   clock,
    input  logic                   reset,
    input  xtea_pkg::cfg_write_t   cfg,
    output xtea_pkg::cipher_key_t  key,
    output xtea_pkg::cipher_mode_t mode
);

    xtea_pkg::cipher_key_t  key_q;
    xtea_pkg::cipher_mode_t mode_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            key_q  <= '0;
            mode_q <= xtea_pkg::MODE_ENCRYPT;
        end else if (cfg.strobe) begin
            case (cfg.addr)
                `XTEA_ADDR_KEY0: begin
                    key_q.k0 <= cfg.data;
                end
                `XTEA_ADDR_KEY1: begin
                    key_q.k1 <= cfg.data;
                end
                `XTEA_ADDR_KEY2: begin
                    key_q.k2 <= cfg.data;
                end
                `XTEA_ADDR_KEY3: begin
                    key_q.k3 <= cfg.data;
                end
                `XTEA_ADDR_MODE: begin
                    mode_q <= xtea_pkg::cipher_mode_t'(cfg.data[0]); // bit 0 only.
                end
                default: begin
                    // unmapped address, write dropped.
                end
            endcase
        end
    end

    // engine samples these only when it accepts a start.
    assign key  = key_q;
    assign mode = mode_q;

endmodule

// File: src/xtea_lane_round.sv
module xtea_lane_round (
    input  xtea_pkg::half_block_t  block,
    input  xtea_pkg::cipher_key_t  key,
    input  logic [31:0]            sum,
    input  xtea_pkg::half_phase_t  phase,
    input  xtea_pkg::cipher_mode_t mode,
    output xtea_pkg::half_block_t  next_block
);

    logic [1:0]  key_idx;
    logic [31:0] key_word;
    logic [31:0] other;
    logic [31:0] target;
    logic [31:0] mix;
    logic [31:0] updated;

    // v0 uses sum[1:0], v1 uses sum[12:11].
    assign key_idx = (phase == xtea_pkg::PHASE_V0) ? sum[1:0] : sum[12:11];

    always_comb begin
        case (key_idx)
            2'd0:    key_word = key.k0;
            2'd1:    key_word = key.k1;
            2'd2:    key_word = key.k2;
            default: key_word = key.k3;
        endcase
    end

    assign other  = (phase == xtea_pkg::PHASE_V0) ? block.v1 : block.v0;
    assign target = (phase == xtea_pkg::PHASE_V0) ? block.v0 : block.v1;

    assign mix = (((other << 4) ^ (other >> 5)) + other) ^ (sum + key_word);

    assign updated = (mode == xtea_pkg::MODE_ENCRYPT) ? target + mix : target - mix;

    always_comb begin
        next_block = block; // untouched half passes through.
        if (phase == xtea_pkg::PHASE_V0) begin
            next_block.v0 = updated;
        end else begin
            next_block.v1 = updated;
        end
    end

endmodule

// File: src/xtea_round_engine.sv
`include "xtea_config.svh"

module xtea_round_engine (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  xtea_pkg::data_block_t  block_in,
    input  xtea_pkg::cipher_key_t  key,
    input  xtea_pkg::cipher_mode_t mode,
    output logic                   busy,
    output logic                   done,
    output xtea_pkg::data_block_t  block_out
);

    localparam int ROUND_W = ($clog2(`XTEA_ROUNDS) > 0) ? $clog2(`XTEA_ROUNDS) : 1;
    localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(`XTEA_ROUNDS - 1);
    localparam logic [31:0] DELTA = `XTEA_DELTA;
    localparam logic [31:0] SUM_DECRYPT = 32'(`XTEA_DELTA * `XTEA_ROUNDS); // mod 2^32.

    typedef enum logic [1:0] {
        S_IDLE,
        S_HALF1,
        S_HALF2,
        S_FINISH
    } state_t;

    state_t                 state;
    logic [ROUND_W-1:0]     round_cnt;
    logic [31:0]            sum;
    logic [31:0]            sum_step;
    logic [31:0]            lane_sum;
    xtea_pkg::data_block_t  blk;
    xtea_pkg::cipher_key_t  key_q;
    xtea_pkg::cipher_mode_t mode_q;
    xtea_pkg::half_phase_t  phase;
    xtea_pkg::half_block_t  next_hi;
    xtea_pkg::half_block_t  next_lo;
    logic                   accept;

    assign accept = (state == S_IDLE) && start;
    assign busy   = (state != S_IDLE);

    // encrypt walks v0 then v1, decrypt the reverse.
    always_comb begin
        if (state == S_HALF2) begin
            phase = (mode_q == xtea_pkg::MODE_ENCRYPT) ? xtea_pkg::PHASE_V1
                                                       : xtea_pkg::PHASE_V0;
        end else begin
            phase = (mode_q == xtea_pkg::MODE_ENCRYPT) ? xtea_pkg::PHASE_V0
                                                       : xtea_pkg::PHASE_V1;
        end
    end

    assign sum_step = (mode_q == xtea_pkg::MODE_ENCRYPT) ? sum + DELTA : sum - DELTA;
    assign lane_sum = (state == S_HALF2) ? sum_step : sum; // second half sees stepped sum.

    xtea_lane_round u_lane_hi (
        .block      (blk.lane_hi),
        .key        (key_q),
        .sum        (lane_sum),
        .phase      (phase),
        .mode       (mode_q),
        .next_block (next_hi)
    );

    xtea_lane_round u_lane_lo (
        .block      (blk.lane_lo),
        .key        (key_q),
        .sum        (lane_sum),
        .phase      (phase),
        .mode       (mode_q),
        .next_block (next_lo)
    );

    // operands and working state.
    always_ff @(posedge clock) begin
        if (accept) begin
            blk    <= block_in;
            key_q  <= key;
            mode_q <= mode;
            sum    <= (mode == xtea_pkg::MODE_ENCRYPT) ? 32'd0 : SUM_DECRYPT;
        end else if (state == S_HALF1) begin
            blk <= '{lane_hi: next_hi, lane_lo: next_lo};
        end else if (state == S_HALF2) begin
            blk <= '{lane_hi: next_hi, lane_lo: next_lo};
            sum <= sum_step;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= S_IDLE;
            round_cnt <= '0;
            done      <= 1'b0;
            block_out <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    round_cnt <= '0;
                    if (start) begin
                        state <= S_HALF1;
                    end
                end
                S_HALF1: begin
                    state <= S_HALF2;
                end
                S_HALF2: begin
                    round_cnt <= round_cnt + 1'b1;
                    if (round_cnt == LAST_ROUND) begin
                        state <= S_FINISH; // last update lands here.
                    end else begin
                        state <= S_HALF1;
                    end
                end
                S_FINISH: begin
                    state     <= S_IDLE;
                    block_out <= blk;
                    done      <= 1'b1;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/xtea_unit.sv
module xtea_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  xtea_pkg::cfg_write_t  cfg,
    input  logic                  start,
    input  xtea_pkg::data_block_t block_in,
    output logic                  busy,
    output logic                  done,
    output xtea_pkg::data_block_t block_out
);

    xtea_pkg::cipher_key_t  key;
    xtea_pkg::cipher_mode_t mode;

    xtea_key_regs u_key_regs (
        .clock (clock),
        .reset (reset),
        .cfg   (cfg),
        .key   (key),
        .mode  (mode)
    );

    // key and mode are captured by the engine at start.
    xtea_round_engine u_engine (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .block_in  (block_in),
        .key       (key),
        .mode      (mode),
        .busy      (busy),
        .done      (done),
        .block_out (block_out)
    );

endmodule

// File: verif/xtea_properties.sv
module xtea_properties (
    input logic clock,
    input logic reset,
    input logic start,
    input logic busy,
    input logic done
);

    timeunit 1ns;
    timeprecision 100ps;

    logic accepted;

    assign accepted = start && !busy; // engine idle when it samples start.

    // done registered 65 edges after the accepting edge, visible at the next one.
    done_after_start: assert property (@(posedge clock) disable iff (reset)
        accepted |-> ##66 done)
        else $error("done missing 65 cycles after an accepted start");

    done_needs_start: assert property (@(posedge clock) disable iff (reset)
        done |-> $past(accepted, 66))
        else $error("done without an accepted start 65 cycles earlier");

    single_done: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else $error("done high on two consecutive cycles");

    idle_on_done: assert property (@(posedge clock) disable iff (reset)
        done |-> !busy)
        else $error("busy high while done is high");

    quiet_after_reset: assert property (@(posedge clock)
        reset |=> (!busy && !done))
        else $error("busy or done high in the cycle after reset");

endmodule

// File: verif/xtea_tb.sv
`include "xtea_config.svh"

module xtea_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RANDOM  = 20;
    localparam int NUM_OPS     = 3 * NUM_RANDOM + 4;
    localparam int CYCLE_LIMIT = NUM_OPS * 70 + 200;
    localparam int DONE_DELAY  = 67; // drive edge, accept edge, 65 edges, then sampling edge.

    typedef struct packed {
        xtea_pkg::data_block_t block;
        logic [31:0]           due;
    } expect_t;

    logic                   clock;
    logic                   reset;
    xtea_pkg::cfg_write_t   cfg;
    logic                   start;
    xtea_pkg::data_block_t  block_in;
    logic                   busy;
    logic                   done;
    xtea_pkg::data_block_t  block_out;

    xtea_pkg::cipher_key_t  model_key;
    xtea_pkg::cipher_mode_t model_mode;
    xtea_pkg::data_block_t  last_out;
    expect_t                expected_q [$];
    logic [31:0]            rng_state;
    logic [31:0]            cycle;
    int                     checks;
    int                     errors;

    xtea_unit UUT (
        .clock     (clock),
        .reset     (reset),
        .cfg       (cfg),
        .start     (start),
        .block_in  (block_in),
        .busy      (busy),
        .done      (done),
        .block_out (block_out)
    );

    bind xtea_round_engine xtea_properties u_properties (
        .clock (clock),
        .reset (reset),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 32'd1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic xtea_pkg::data_block_t random_block();
        xtea_pkg::data_block_t blk;
        blk.lane_hi.v0 = next_random();
        blk.lane_hi.v1 = next_random();
        blk.lane_lo.v0 = next_random();
        blk.lane_lo.v1 = next_random();
        return blk;
    endfunction

    // textbook xtea on one 64-bit block.
    function automatic xtea_pkg::half_block_t xtea_reference(
        input xtea_pkg::half_block_t  blk,
        input xtea_pkg::cipher_key_t  key,
        input xtea_pkg::cipher_mode_t mode
    );
        logic [31:0] k [0:3];
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] s;
        xtea_pkg::half_block_t res;
        k[0] = key.k0;
        k[1] = key.k1;
        k[2] = key.k2;
        k[3] = key.k3;
        y = blk.v0;
        z = blk.v1;
        if (mode == xtea_pkg::MODE_ENCRYPT) begin
            s = 32'd0;
            for (int i = 0; i < `XTEA_ROUNDS; i++) begin
                y += (((z << 4) ^ (z >> 5)) + z) ^ (s + k[s[1:0]]);
                s += `XTEA_DELTA;
                z += (((y << 4) ^ (y >> 5)) + y) ^ (s + k[s[12:11]]);
            end
        end else begin
            s = 32'(`XTEA_DELTA * `XTEA_ROUNDS);
            for (int i = 0; i < `XTEA_ROUNDS; i++) begin
                z -= (((y << 4) ^ (y >> 5)) + y) ^ (s + k[s[12:11]]);
                s -= `XTEA_DELTA;
                y -= (((z << 4) ^ (z >> 5)) + z) ^ (s + k[s[1:0]]);
            end
        end
        res.v0 = y;
        res.v1 = z;
        return res;
    endfunction

    function automatic xtea_pkg::data_block_t reference_block(input xtea_pkg::data_block_t blk);
        xtea_pkg::data_block_t res;
        res.lane_hi = xtea_reference(blk.lane_hi, model_key, model_mode);
        res.lane_lo = xtea_reference(blk.lane_lo, model_key, model_mode);
        return res;
    endfunction

    task automatic check_block(input string name, input xtea_pkg::data_block_t expected,
                               input xtea_pkg::data_block_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic write_reg(input logic [2:0] waddr, input logic [31:0] wdata);
        @(posedge clock);
        cfg <= '{addr: waddr, data: wdata, strobe: 1'b1};
        @(posedge clock);
        cfg <= '0;
        case (waddr)
            `XTEA_ADDR_KEY0: model_key.k0 = wdata;
            `XTEA_ADDR_KEY1: model_key.k1 = wdata;
            `XTEA_ADDR_KEY2: model_key.k2 = wdata;
            `XTEA_ADDR_KEY3: model_key.k3 = wdata;
            `XTEA_ADDR_MODE: model_mode = xtea_pkg::cipher_mode_t'(wdata[0]);
            default: ;
        endcase
    endtask

    task automatic write_key(input xtea_pkg::cipher_key_t key);
        write_reg(`XTEA_ADDR_KEY0, key.k0);
        write_reg(`XTEA_ADDR_KEY1, key.k1);
        write_reg(`XTEA_ADDR_KEY2, key.k2);
        write_reg(`XTEA_ADDR_KEY3, key.k3);
    endtask

    task automatic start_operation(input xtea_pkg::data_block_t blk,
                                   input xtea_pkg::data_block_t expected);
        expect_t item;
        @(posedge clock);
        start    <= 1'b1;
        block_in <= blk;
        item.block = expected;
        item.due   = cycle + DONE_DELAY;
        expected_q.push_back(item);
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        check_busy("busy", 1'b1, busy);
    endtask

    task automatic start_while_busy(input xtea_pkg::data_block_t blk);
        @(posedge clock);
        if (busy !== 1'b1) begin
            errors++;
            $display("a start meant to be dropped found the engine idle at cycle %0d", cycle);
        end
        start    <= 1'b1;
        block_in <= blk;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clock);
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
    endtask

    initial begin : compare_results
        expect_t item;
        @(negedge reset);
        forever begin
            @(posedge clock);
            if (done) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("unexpected done at cycle %0d with no operation pending", cycle);
                end else begin
                    item = expected_q.pop_front();
                    checks++;
                    if (cycle != item.due) begin
                        errors++;
                        $display("done arrived at cycle %0d but was due at cycle %0d",
                                 cycle, item.due);
                    end
                    check_block("block_out", item.block, block_out);
                    check_busy("busy", 1'b0, busy);
                end
                last_out = block_out;
            end else begin
                check_block("block_out", last_out, block_out); // holds between dones.
            end
        end
    end

    initial begin : watchdog
        wait (cycle >= 32'(CYCLE_LIMIT));
        $display("timeout after %0d cycles, the run did not finish", cycle);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        xtea_pkg::data_block_t plain [NUM_RANDOM];
        xtea_pkg::data_block_t cipher [NUM_RANDOM];
        xtea_pkg::data_block_t blk;
        xtea_pkg::cipher_key_t new_key;
        clock      = 1'b0;
        reset      = 1'b1;
        cfg        = '0;
        start      = 1'b0;
        block_in   = '0;
        cycle      = 32'd0;
        rng_state  = 32'h4;
        checks     = 0;
        errors     = 0;
        model_key  = '0;
        model_mode = xtea_pkg::MODE_ENCRYPT;
        last_out   = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_busy("busy", 1'b0, busy);
        check_busy("done", 1'b0, done);
        check_block("block_out", '0, block_out);

        // zero key straight out of reset.
        start_operation('0, reference_block('0));
        wait_idle();

        write_key('{k0: 32'h00010203, k1: 32'h04050607, k2: 32'h08090A0B, k3: 32'h0C0D0E0F});
        write_reg(3'd5, 32'hFFFF_FFFF); // unmapped, must be ignored.
        blk = '{lane_hi: '{v0: 32'h41424344, v1: 32'h45464748},
                lane_lo: '{v0: 32'h01234567, v1: 32'h89ABCDEF}};
        start_operation(blk, reference_block(blk));
        wait_idle();

        new_key.k0 = next_random();
        new_key.k1 = next_random();
        new_key.k2 = next_random();
        new_key.k3 = next_random();
        write_key(new_key);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            plain[i]  = random_block();
            cipher[i] = reference_block(plain[i]);
            start_operation(plain[i], cipher[i]);
            wait_idle();
        end

        write_reg(`XTEA_ADDR_MODE, 32'd1);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            blk = random_block();
            start_operation(blk, reference_block(blk));
            wait_idle();
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            start_operation(cipher[i], plain[i]); // round trip back to plaintext.
            wait_idle();
        end

        // writes and a second start land mid-operation.
        blk = random_block();
        start_operation(blk, reference_block(blk));
        repeat (3) @(posedge clock);
        start_while_busy(random_block());
        new_key.k0 = next_random();
        new_key.k1 = next_random();
        new_key.k2 = next_random();
        new_key.k3 = next_random();
        write_key(new_key);
        write_reg(`XTEA_ADDR_MODE, 32'd0);
        start_while_busy(random_block());
        @(negedge clock);
        check_busy("busy", 1'b1, busy);
        wait_idle();
        blk = random_block();
        start_operation(blk, reference_block(blk));
        wait_idle();

        repeat (4) @(posedge clock);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
src/xtea_pkg.sv
src/xtea_key_regs.sv
src/xtea_lane_round.sv
src/xtea_round_engine.sv
src/xtea_unit.sv
verif/xtea_properties.sv
verif/xtea_tb.sv

// File: Makefile
# Verilator build and run for the XTEA unit testbench.

SIM_DIR         ?= obj_dir
TOP             ?= xtea_tb
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
FILE_LIST       ?= tb.f
LOG             ?= $(SIM_DIR)/sim.log
PASS_TEXT       := Done: no errors

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR)
